// File: gnn_fv_bank.f
rtl/fv_pkg.sv
rtl/fv_sram_if.sv
rtl/fv_stream_if.sv
rtl/fv_bank_cntl.sv
rtl/fv_sram_bank.sv
rtl/sm_fv_buffer.sv
rtl/fv_bank_top.sv
bench/tb_fv_bank.sv

// File: run_sim.sh
#!/bin/sh
# build the feature bank testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fv_bank \
    -f gnn_fv_bank.f -o tb_fv_bank_sim \
    && ./obj_dir/tb_fv_bank_sim | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/tb_fv_bank.sv
/* testbench for the feature-value bank: stimulus, SRAM reference model
   and the assertions that check edge reads, streams and lookups */
`default_nettype none

module tb_fv_bank import fv_pkg::*; ();

    localparam int         TIMEOUT_CYCLES = 200;
    localparam logic [4:0] STRM_LAST      = 5'(NODES_PER_ITER * LINES_PER_NODE - 1);

    logic                  clk = 1'b0;
    logic                  reset;
    logic [ITER_W-1:0]     replay_iter;
    logic [UPD_ITER_W-1:0] update_iter;
    logic [FV_CNT_W-1:0]   fv_num;
    logic                  stream_begin;
    logic                  req_valid, req_rd_wr, req_wr_eos;
    logic [NODE_ID_W-1:0]  req_node_id;
    logic [PE_TAG_W-1:0]   req_pe_tag;
    line_t                 req_data;
    logic                  rd_valid, rd_sos, rd_eos;
    logic [PE_TAG_W-1:0]   rd_pe_tag;
    line_t                 rd_data;
    logic                  strm_sos, strm_eos;
    logic [SM_ADDR_W-1:0]  sm_rd_addr;
    line_t                 sm_rd_data;
    logic                  available;

    // mirror of every line written to the SRAM
    line_t model [SRAM_DEPTH];

    // expectations set along with the stimulus
    string                 test_name;
    logic [NODE_ID_W-1:0]  exp_node;
    logic [PE_TAG_W-1:0]   exp_tag;
    logic [LINE_IDX_W-1:0] exp_last;
    logic [ITER_W-1:0]     exp_iter;
    logic                  op_busy, strm_allowed, look_en;

    // progress seen on the outputs
    logic [LINE_IDX_W-1:0] rd_idx;
    logic                  in_strm, look_q;
    logic [4:0]            strm_cyc;
    logic [SM_ADDR_W-1:0]  look_addr_q;

    int check_errors   = 0;
    int timeout_errors = 0;

    always #20 clk = ~clk;

    fv_bank_top i_dut (
        .clk(clk), .reset(reset), .replay_iter(replay_iter), .update_iter(update_iter),
        .fv_num(fv_num), .stream_begin(stream_begin), .req_valid(req_valid),
        .req_rd_wr(req_rd_wr), .req_wr_eos(req_wr_eos), .req_node_id(req_node_id),
        .req_pe_tag(req_pe_tag), .req_data(req_data), .rd_valid(rd_valid),
        .rd_sos(rd_sos), .rd_eos(rd_eos), .rd_pe_tag(rd_pe_tag), .rd_data(rd_data),
        .strm_sos(strm_sos), .strm_eos(strm_eos), .sm_rd_addr(sm_rd_addr),
        .sm_rd_data(sm_rd_data), .available(available)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_idx   <= '0;
            in_strm  <= 1'b0;
            strm_cyc <= '0;
            look_q   <= 1'b0;
        end else begin
            if (rd_valid) begin
                rd_idx <= rd_eos ? '0 : rd_idx + 1'b1;
            end
            // cycles since the stream's first line
            if (strm_sos) begin
                in_strm  <= 1'b1;
                strm_cyc <= 5'd1;
            end else if (in_strm) begin
                strm_cyc <= strm_cyc + 1'b1;
            end
            if (strm_eos) begin
                in_strm <= 1'b0;
            end
            look_q <= look_en;
        end
        look_addr_q <= sm_rd_addr;
    end

    function automatic void report_mismatch(input string what, input logic [63:0] exp_val,
                                            input logic [63:0] act_val);
        $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp_val, act_val);
        check_errors++;
    endfunction

    // ceil(fv/4) lines, never fewer than one
    function automatic logic [LINE_IDX_W-1:0] last_line_of(input logic [FV_CNT_W-1:0] fv);
        int n;
        n = (fv == '0) ? 1 : (int'(fv) + FV_PER_LINE - 1) / FV_PER_LINE;
        return LINE_IDX_W'(n - 1);
    endfunction

    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        (available && !rd_valid && !strm_sos && !strm_eos))
        else report_mismatch("reset outputs", 64'(4'b1000),
                             64'({$sampled(available), $sampled(rd_valid),
                                  $sampled(strm_sos), $sampled(strm_eos)}));
    a_rd_data: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (rd_data == model[{exp_node, rd_idx}]))
        else report_mismatch("rd_data", model[{$sampled(exp_node), $sampled(rd_idx)}],
                             $sampled(rd_data));
    a_rd_tag: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (rd_pe_tag == exp_tag))
        else report_mismatch("rd_pe_tag", 64'($sampled(exp_tag)), 64'($sampled(rd_pe_tag)));
    a_rd_sos: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (rd_sos == (rd_idx == '0)))
        else report_mismatch("rd_sos", 64'($sampled(rd_idx) == '0), 64'($sampled(rd_sos)));
    a_rd_eos: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (rd_eos == (rd_idx == exp_last)))
        else report_mismatch("rd_eos", 64'($sampled(rd_idx) == $sampled(exp_last)),
                             64'($sampled(rd_eos)));
    a_busy: assert property (@(posedge clk) disable iff (reset)
        op_busy |-> !available)
        else report_mismatch("available while busy", 64'(0), 64'($sampled(available)));
    a_idle_again: assert property (@(posedge clk) disable iff (reset)
        $fell(op_busy) |-> available)
        else report_mismatch("available after operation", 64'(1), 64'($sampled(available)));
    a_strm_start: assert property (@(posedge clk) disable iff (reset)
        strm_sos |-> (strm_allowed && !in_strm))
        else report_mismatch("strm_sos allowed", 64'(1),
                             64'($sampled(strm_allowed) && !$sampled(in_strm)));
    a_strm_end: assert property (@(posedge clk) disable iff (reset)
        strm_eos |-> (in_strm && strm_cyc == STRM_LAST))
        else report_mismatch("strm_eos position", 64'(STRM_LAST), 64'($sampled(strm_cyc)));
    a_lookup: assert property (@(posedge clk) disable iff (reset)
        look_q |-> (sm_rd_data == model[{exp_iter, look_addr_q}]))
        else report_mismatch("sm_rd_data", model[{$sampled(exp_iter), $sampled(look_addr_q)}],
                             $sampled(sm_rd_data));

    task automatic wait_until(input string what);
        int   cycles;
        logic hit;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            hit = (what == "available") ? available : (what == "rd_eos") ? rd_eos : strm_eos;
        end while (!hit && cycles < TIMEOUT_CYCLES);
        if (!hit) begin
            $display("timeout: %s never went high during %s", what, test_name);
            timeout_errors++;
        end
    endtask

    task automatic write_node(input logic [NODE_ID_W-1:0] node);
        line_t data;
        wait_until("available");
        for (int k = 0; k < LINES_PER_NODE; k++) begin
            data = {$urandom(), $urandom()};
            model[{node, LINE_IDX_W'(k)}] = data;
            @(posedge clk);
            req_valid   <= (k == 0);
            req_rd_wr   <= 1'b1;
            req_wr_eos  <= (k == LINES_PER_NODE - 1);
            req_node_id <= node;
            req_data    <= data;
            op_busy     <= (k != 0);
        end
        @(posedge clk);
        req_valid  <= 1'b0;
        req_wr_eos <= 1'b0;
        op_busy    <= 1'b0;
    endtask

    task automatic edge_read(input logic [NODE_ID_W-1:0] node, input logic [FV_CNT_W-1:0] fv,
                             input logic [PE_TAG_W-1:0] tag);
        wait_until("available");
        @(posedge clk);
        req_valid   <= 1'b1;
        req_rd_wr   <= 1'b0;
        req_node_id <= node;
        req_pe_tag  <= tag;
        fv_num      <= fv;
        exp_node    <= node;
        exp_tag     <= tag;
        exp_last    <= last_line_of(fv);
        @(posedge clk);
        req_valid <= 1'b0;
        op_busy   <= 1'b1;
        wait_until("rd_eos");
        @(posedge clk);
        op_busy <= 1'b0;
    endtask

    // stream one iteration, then look up every small-buffer line
    task automatic run_stream(input logic [ITER_W-1:0] iter, input logic by_begin);
        wait_until("available");
        @(posedge clk);
        strm_allowed <= 1'b1;
        exp_iter     <= iter;
        if (by_begin) begin
            stream_begin <= 1'b1;
        end else begin
            replay_iter <= iter;
        end
        @(posedge clk);
        stream_begin <= 1'b0;
        op_busy      <= 1'b1;
        wait_until("strm_eos");
        @(posedge clk);
        op_busy      <= 1'b0;
        strm_allowed <= 1'b0;
        for (int a = 0; a < (1 << SM_ADDR_W); a++) begin
            @(posedge clk);
            sm_rd_addr <= SM_ADDR_W'(a);
            look_en    <= 1'b1;
        end
        @(posedge clk);
        look_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic end_run();
        $display("errors: checks=%0d timeouts=%0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        logic [FV_CNT_W-1:0] fv;
        reset        <= 1'b1;
        replay_iter  <= '0;
        update_iter  <= '0;
        fv_num       <= '0;
        stream_begin <= 1'b0;
        req_valid    <= 1'b0;
        req_rd_wr    <= 1'b0;
        req_wr_eos   <= 1'b0;
        req_node_id  <= '0;
        req_pe_tag   <= '0;
        req_data     <= '0;
        sm_rd_addr   <= '0;
        exp_node     <= '0;
        exp_tag      <= '0;
        exp_last     <= '0;
        exp_iter     <= '0;
        op_busy      <= 1'b0;
        strm_allowed <= 1'b0;
        look_en      <= 1'b0;
        test_name = "reset";
        void'($urandom(32'h23a2));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);

        test_name = "write_back";
        for (int n = 0; n < SRAM_DEPTH / LINES_PER_NODE; n++) begin
            write_node(NODE_ID_W'(n));
        end

        test_name = "edge_read";
        for (int i = 0; i < 12; i++) begin
            if (i == 0) begin
                fv = '0;
            end else if (i == 1) begin
                fv = FV_CNT_W'(MAX_FV_NUM);
            end else begin
                fv = FV_CNT_W'($urandom_range(MAX_FV_NUM, 0));
            end
            edge_read(NODE_ID_W'($urandom_range(15, 0)), fv, PE_TAG_W'($urandom()));
        end

        // even update iteration, an iteration change must not stream
        test_name = "iter_even";
        @(posedge clk);
        update_iter <= 3'd2;
        replay_iter <= 2'd2;
        repeat (8) @(posedge clk);
        replay_iter <= '0;
        @(posedge clk);

        test_name = "stream_begin";
        update_iter <= 3'd1;
        fv_num      <= FV_CNT_W'(MAX_FV_NUM);
        run_stream(2'd0, 1'b1);

        test_name = "iter_change";
        run_stream(2'd3, 1'b0);
        @(posedge clk);
        update_iter <= '0;
        repeat (4) @(posedge clk);
        end_run();
    end

endmodule

`default_nettype wire

// File: rtl/fv_bank_top.sv
/* feature-value bank top: controller, SRAM bank and small buffer on plain ports */
`default_nettype none

module fv_bank_top import fv_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [ITER_W-1:0]     replay_iter,
    input  wire logic [UPD_ITER_W-1:0] update_iter,
    input  wire logic [FV_CNT_W-1:0]   fv_num,
    input  wire logic                  stream_begin,
    input  wire logic                  req_valid,
    input  wire logic                  req_rd_wr,
    input  wire logic                  req_wr_eos,
    input  wire logic [NODE_ID_W-1:0]  req_node_id,
    input  wire logic [PE_TAG_W-1:0]   req_pe_tag,
    input  wire line_t                 req_data,
    output logic                       rd_valid,
    output logic                       rd_sos,
    output logic                       rd_eos,
    output logic [PE_TAG_W-1:0]        rd_pe_tag,
    output line_t                      rd_data,
    output logic                       strm_sos,
    output logic                       strm_eos,
    input  wire logic [SM_ADDR_W-1:0]  sm_rd_addr,
    output line_t                      sm_rd_data,
    output logic                       available
);

    fv_req_t req;

    fv_sram_if   sram_bus ();
    fv_stream_if strm_bus ();

    assign req = '{
        valid:   req_valid,
        rd_wr:   req_rd_wr,
        wr_eos:  req_wr_eos,
        node_id: req_node_id,
        pe_tag:  req_pe_tag,
        data:    req_data
    };

    fv_bank_cntl i_cntl (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .fv_num       (fv_num),
        .stream_begin (stream_begin),
        .req          (req),
        .sram         (sram_bus.cntl),
        .strm         (strm_bus.src),
        .rd_valid     (rd_valid),
        .rd_sos       (rd_sos),
        .rd_eos       (rd_eos),
        .rd_pe_tag    (rd_pe_tag),
        .rd_data      (rd_data),
        .available    (available)
    );

    fv_sram_bank i_sram (
        .clk  (clk),
        .port (sram_bus.mem)
    );

    sm_fv_buffer i_sm_buf (
        .clk        (clk),
        .reset      (reset),
        .sm_rd_addr (sm_rd_addr),
        .strm       (strm_bus.dst),
        .sm_rd_data (sm_rd_data)
    );

    // stream framing for the outside
    assign strm_sos = strm_bus.sos;
    assign strm_eos = strm_bus.eos;

endmodule

`default_nettype wire

// File: rtl/sm_fv_buffer.sv
/* small feature buffer, one iteration of streamed lines with registered lookup */
`default_nettype none

module sm_fv_buffer import fv_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [SM_ADDR_W-1:0] sm_rd_addr,
    fv_stream_if.dst                  strm,
    output line_t                     sm_rd_data
);

    localparam int SM_DEPTH = 1 << SM_ADDR_W;

    line_t buf_mem [SM_DEPTH];
    logic  in_stream;

    // newer iterations overwrite in place
    always_ff @(posedge clk) begin
        if (strm.valid) begin
            buf_mem[strm.addr] <= strm.data;
        end
        sm_rd_data <= buf_mem[sm_rd_addr];
    end

    // open between sos and eos
    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream <= 1'b0;
        end else if (strm.valid && strm.eos) begin
            in_stream <= 1'b0;
        end else if (strm.valid && strm.sos) begin
            in_stream <= 1'b1;
        end
    end

    a_eos_after_sos: assert property (@(posedge clk) disable iff (reset)
        strm.eos |-> (in_stream || strm.sos));

    a_marks_need_valid: assert property (@(posedge clk) disable iff (reset)
        (strm.sos || strm.eos) |-> strm.valid);

endmodule

`default_nettype wire

// File: rtl/fv_sram_bank.sv
/* single-port feature SRAM, active-low enables, registered read */
`default_nettype none

module fv_sram_bank import fv_pkg::*; (
    input wire logic clk,
    fv_sram_if.mem   port
);

    line_t mem [SRAM_DEPTH];
    line_t rdata_q;

    // write on wen low, read on wen high
    always_ff @(posedge clk) begin
        if (!port.cen) begin
            if (!port.wen) begin
                mem[port.addr] <= port.wdata;
            end else begin
                rdata_q <= mem[port.addr];
            end
        end
    end

    // holds the last read line between reads
    assign port.rdata = rdata_q;

    a_addr_range: assert property (@(posedge clk)
        !port.cen |-> (!$isunknown(port.addr) && (int'(port.addr) < SRAM_DEPTH)));

endmodule

`default_nettype wire

// File: rtl/fv_bank_cntl.sv
/* feature bank controller: write-back, edge read and
   iteration streaming FSM with a two-stage read pipeline */
`default_nettype none

module fv_bank_cntl import fv_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [ITER_W-1:0]     replay_iter,
    input  wire logic [UPD_ITER_W-1:0] update_iter,
    input  wire logic [FV_CNT_W-1:0]   fv_num,
    input  wire logic                  stream_begin,
    input  wire fv_req_t               req,
    fv_sram_if.cntl                    sram,
    fv_stream_if.src                   strm,
    output logic                       rd_valid,
    output logic                       rd_sos,
    output logic                       rd_eos,
    output logic [PE_TAG_W-1:0]        rd_pe_tag,
    output line_t                      rd_data,
    output logic                       available
);

    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        STREAM_ITER  = 2'd1,
        WRITE_BACK   = 2'd2,
        READ_TO_EDGE = 2'd3
    } state_t;

    state_t state, nx_state;

    logic [LINE_IDX_W-1:0] line_cnt, nx_line_cnt;
    logic [NODE_IDX_W-1:0] node_cnt, nx_node_cnt;
    logic [LINE_IDX_W-1:0] last_line_q, nx_last_line;
    logic [ITER_W-1:0]     cur_iter, nx_iter;
    logic [NODE_ID_W-1:0]  node_id_q, nx_node_id;
    logic [PE_TAG_W-1:0]   pe_tag_q, nx_pe_tag;
    logic                  iss_done, nx_iss_done;

    logic [FV_CNT_W-1:0]   fv_minus1;
    logic [LINE_IDX_W-1:0] fv_last;
    logic                  stream_trig;

    // SRAM drive and issue flags for the current cycle
    logic                  mem_cen, mem_wen;
    logic [ADDR_W-1:0]     mem_addr;
    line_t                 mem_wdata;
    logic                  iss_rd, iss_st, iss_first, iss_last;

    // stage 1, lined up with sram.rdata
    logic                  s1_rd, s1_st, s1_first, s1_last;
    logic [SM_ADDR_W-1:0]  s1_addr;

    // index of the last line, ceil(fv_num/4)-1, at least line 0
    assign fv_minus1 = fv_num - FV_CNT_W'(1);
    assign fv_last   = (fv_num == '0) ? '0 : fv_minus1[$clog2(FV_PER_LINE) +: LINE_IDX_W];

    assign stream_trig = update_iter[0] && (stream_begin || (replay_iter != cur_iter));
    assign available   = (state == IDLE);

    assign sram.cen   = mem_cen;
    assign sram.wen   = mem_wen;
    assign sram.addr  = mem_addr;
    assign sram.wdata = mem_wdata;

    always_comb begin
        mem_cen      = 1'b1;
        mem_wen      = 1'b1;
        mem_addr     = '0;
        mem_wdata    = '0;
        iss_rd       = 1'b0;
        iss_st       = 1'b0;
        iss_first    = 1'b0;
        iss_last     = 1'b0;
        nx_state     = state;
        nx_line_cnt  = line_cnt;
        nx_node_cnt  = node_cnt;
        nx_last_line = last_line_q;
        nx_iter      = cur_iter;
        nx_node_id   = node_id_q;
        nx_pe_tag    = pe_tag_q;
        nx_iss_done  = iss_done;

        case (state)
            IDLE: begin
                nx_iss_done = 1'b0;
                if (stream_trig) begin
                    // first line of node 0 goes out right away
                    nx_state     = STREAM_ITER;
                    mem_cen      = 1'b0;
                    mem_addr     = {replay_iter, {NODE_IDX_W{1'b0}}, {LINE_IDX_W{1'b0}}};
                    iss_st       = 1'b1;
                    iss_first    = 1'b1;
                    nx_iter      = replay_iter;
                    nx_last_line = fv_last;
                    if (fv_last == '0) begin
                        nx_line_cnt = '0;
                        nx_node_cnt = NODE_IDX_W'(1);
                    end else begin
                        nx_line_cnt = LINE_IDX_W'(1);
                        nx_node_cnt = '0;
                    end
                end else if (req.valid) begin
                    nx_node_id = req.node_id;
                    mem_cen    = 1'b0;
                    mem_addr   = {req.node_id, {LINE_IDX_W{1'b0}}};
                    if (req.rd_wr) begin
                        mem_wen   = 1'b0;
                        mem_wdata = req.data;
                        if (!req.wr_eos) begin
                            nx_state    = WRITE_BACK;
                            nx_line_cnt = LINE_IDX_W'(1);
                        end
                    end else begin
                        nx_state     = READ_TO_EDGE;
                        iss_rd       = 1'b1;
                        iss_first    = 1'b1;
                        nx_pe_tag    = req.pe_tag;
                        nx_last_line = fv_last;
                        if (fv_last == '0) begin
                            iss_last    = 1'b1;
                            nx_iss_done = 1'b1;
                        end else begin
                            nx_line_cnt = LINE_IDX_W'(1);
                        end
                    end
                end
            end

            WRITE_BACK: begin
                mem_cen     = 1'b0;
                mem_wen     = 1'b0;
                mem_addr    = {node_id_q, line_cnt};
                mem_wdata   = req.data;
                nx_line_cnt = line_cnt + 1'b1;
                if (req.wr_eos) begin
                    nx_state    = IDLE;
                    nx_line_cnt = '0;
                end
            end

            READ_TO_EDGE: begin
                if (!iss_done) begin
                    mem_cen  = 1'b0;
                    mem_addr = {node_id_q, line_cnt};
                    iss_rd   = 1'b1;
                    if (line_cnt == last_line_q) begin
                        iss_last    = 1'b1;
                        nx_iss_done = 1'b1;
                        nx_line_cnt = '0;
                    end else begin
                        nx_line_cnt = line_cnt + 1'b1;
                    end
                end
                // leave once the last line sits on the output
                if (rd_valid && rd_eos) begin
                    nx_state = IDLE;
                end
            end

            STREAM_ITER: begin
                if (!iss_done) begin
                    mem_cen  = 1'b0;
                    mem_addr = {cur_iter, node_cnt, line_cnt};
                    iss_st   = 1'b1;
                    if (line_cnt == last_line_q) begin
                        nx_line_cnt = '0;
                        // next node follows with no gap
                        if (node_cnt == NODE_IDX_W'(NODES_PER_ITER - 1)) begin
                            iss_last    = 1'b1;
                            nx_iss_done = 1'b1;
                            nx_node_cnt = '0;
                        end else begin
                            nx_node_cnt = node_cnt + 1'b1;
                        end
                    end else begin
                        nx_line_cnt = line_cnt + 1'b1;
                    end
                end
                if (strm.valid && strm.eos) begin
                    nx_state = IDLE;
                end
            end

            default: nx_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            line_cnt    <= '0;
            node_cnt    <= '0;
            last_line_q <= '0;
            cur_iter    <= '0;
            iss_done    <= 1'b0;
            s1_rd       <= 1'b0;
            s1_st       <= 1'b0;
            s1_first    <= 1'b0;
            s1_last     <= 1'b0;
            rd_valid    <= 1'b0;
            rd_sos      <= 1'b0;
            rd_eos      <= 1'b0;
            strm.valid  <= 1'b0;
            strm.sos    <= 1'b0;
            strm.eos    <= 1'b0;
        end else begin
            state       <= nx_state;
            line_cnt    <= nx_line_cnt;
            node_cnt    <= nx_node_cnt;
            last_line_q <= nx_last_line;
            cur_iter    <= nx_iter;
            iss_done    <= nx_iss_done;
            s1_rd       <= iss_rd;
            s1_st       <= iss_st;
            s1_first    <= iss_first;
            s1_last     <= iss_last;
            rd_valid    <= s1_rd;
            rd_sos      <= s1_rd && s1_first;
            rd_eos      <= s1_rd && s1_last;
            strm.valid  <= s1_st;
            strm.sos    <= s1_st && s1_first;
            strm.eos    <= s1_st && s1_last;
        end
    end

    // request latches and data path
    always_ff @(posedge clk) begin
        node_id_q <= nx_node_id;
        pe_tag_q  <= nx_pe_tag;
        s1_addr   <= mem_addr[SM_ADDR_W-1:0];
        rd_pe_tag <= pe_tag_q;
        rd_data   <= sram.rdata;
        strm.addr <= s1_addr;
        strm.data <= sram.rdata;
    end

    // sos only on the first line of a read burst
    a_sos_valid: assert property (@(posedge clk) disable iff (reset)
        rd_sos |-> (rd_valid && !$past(rd_valid)));

    // requests only arrive while the FSM is idle
    a_no_accept_busy: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (state == IDLE));

    a_sram_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        ($past(reset) && !req.valid && !stream_trig) |-> (sram.cen && sram.wen));

endmodule

`default_nettype wire

// File: rtl/fv_stream_if.sv
/* stream of one iteration's lines into the small feature buffer */
`default_nettype none

interface fv_stream_if import fv_pkg::*; ();

    logic                 valid;
    // first and last line of a stream
    logic                 sos;
    logic                 eos;
    logic [SM_ADDR_W-1:0] addr;
    line_t                data;

    modport src (
        output valid, sos, eos, addr, data
    );

    modport dst (
        input valid, sos, eos, addr, data
    );

endinterface

`default_nettype wire

// File: rtl/fv_sram_if.sv
/* controller to SRAM bank port, active-low enables */
`default_nettype none

interface fv_sram_if import fv_pkg::*; ();

    logic              cen;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    line_t             wdata;
    // valid the cycle after a read
    line_t             rdata;

    modport cntl (
        output cen, wen, addr, wdata,
        input  rdata
    );

    modport mem (
        input  cen, wen, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: rtl/fv_pkg.sv
/* sizes, address widths, line type and request struct
   shared by the feature-value bank controller, SRAM and small buffer */
`default_nettype none

package fv_pkg;

    // feature values and lines
    localparam int FV_W        = 16;
    localparam int FV_PER_LINE = 4;
    localparam int LINE_W      = FV_W * FV_PER_LINE;

    typedef logic [LINE_W-1:0] line_t;

    // per-node layout, 16 features in 4 lines
    localparam int MAX_FV_NUM     = 16;
    localparam int LINES_PER_NODE = MAX_FV_NUM / FV_PER_LINE;
    localparam int LINE_IDX_W     = $clog2(LINES_PER_NODE);

    // nodes of one replay iteration
    localparam int NODES_PER_ITER = 4;
    localparam int NODE_IDX_W     = $clog2(NODES_PER_ITER);

    localparam int MAX_REPLAY_ITER = 4;
    localparam int ITER_W          = $clog2(MAX_REPLAY_ITER);

    // node id is {iteration, node index}
    localparam int NODE_ID_W = ITER_W + NODE_IDX_W;

    // SRAM address is {node id, line index}
    localparam int ADDR_W     = NODE_ID_W + LINE_IDX_W;
    localparam int SRAM_DEPTH = 1 << ADDR_W;

    // small buffer holds one iteration: {node index, line index}
    localparam int SM_ADDR_W = NODE_IDX_W + LINE_IDX_W;

    // count 0..MAX_FV_NUM inclusive
    localparam int FV_CNT_W   = $clog2(MAX_FV_NUM) + 1;
    localparam int PE_TAG_W   = 2;
    localparam int UPD_ITER_W = 3;

    // requester packet, rd_wr = 1 means write
    typedef struct packed {
        logic                 valid;
        logic                 rd_wr;
        logic                 wr_eos;
        logic [NODE_ID_W-1:0] node_id;
        logic [PE_TAG_W-1:0]  pe_tag;
        line_t                data;
    } fv_req_t;

endpackage

`default_nettype wire
